// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_conv_layer
FILELIST   := all.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
+incdir+.
conv_pkg.sv
feature_ram.sv
coef_rom.sv
mac_array.sv
layer_sequencer.sv
conv_layer_top.sv
tb_conv_layer.sv

// ==== coef_rom.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "conv_settings.svh"

module coef_rom import conv_pkg::*; (
  input  wire         clk,
  input  wire stage_t stage,
  output wmat_t       weights,
  output vec_t        bias
);

  localparam int L = `CONV_LANES;
  localparam int W = `CONV_DATA_W;
  localparam int C = `CONV_COEF_W;

  // weight rule: ((7s + 3i + 5j) mod 11) - 5
  function automatic wmat_t weights_of(int s);
    wmat_t w;
    w = '0;
    for (int i = 0; i < L; i++) begin
      for (int j = 0; j < L; j++) begin
        w[(i*L+j)*C +: C] = coef_t'(((7*s + 3*i + 5*j) % 11) - 5);
      end
    end
    return w;
  endfunction

  // bias rule: ((13s + 9i) mod 32) - 16
  function automatic vec_t bias_of(int s);
    vec_t b;
    b = '0;
    for (int i = 0; i < L; i++) begin
      b[i*W +: W] = elem_t'(((13*s + 9*i) % 32) - 16);
    end
    return b;
  endfunction

  // one cycle latency, same as the feature RAM read
  always_ff @(posedge clk) begin
    weights <= weights_of(int'(stage));
    bias    <= bias_of(int'(stage));
  end

endmodule

`default_nettype wire

// ==== conv_layer_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "conv_settings.svh"

module conv_layer_top import conv_pkg::*; (
  input  wire        clk,
  input  wire        reset,
  input  wire        ld_req,
  input  wire addr_t ld_addr,
  input  wire vec_t  ld_data,
  input  wire        start_req,
  input  wire addr_t rd_addr,
  output logic       ld_ack,
  output logic       start_ack,
  output vec_t       rd_data
);

  // final stage writes bank B when the stage count is odd
  localparam bit RESULT_IN_B = (`CONV_STAGES % 2) == 1;

  stage_t stage;
  addr_t  rd_pos;
  addr_t  wr_pos;
  addr_t  a_raddr;
  addr_t  b_raddr;
  logic   rd_bank_b;
  logic   issue;
  logic   wr_en_a;
  logic   wr_en_b;
  logic   ld_we;
  logic   last_stage;
  logic   mac_valid;
  wmat_t  weights;
  vec_t   bias;
  vec_t   a_rdata;
  vec_t   b_rdata;
  vec_t   a_wdata;
  vec_t   skip_rdata;
  vec_t   mac_x;
  vec_t   mac_y;

  layer_sequencer u_layer_sequencer (
    .clk        (clk),
    .reset      (reset),
    .ld_req     (ld_req),
    .ld_addr    (ld_addr),
    .start_req  (start_req),
    .ld_ack     (ld_ack),
    .start_ack  (start_ack),
    .stage      (stage),
    .rd_pos     (rd_pos),
    .rd_bank_b  (rd_bank_b),
    .issue      (issue),
    .wr_pos     (wr_pos),
    .wr_en_a    (wr_en_a),
    .wr_en_b    (wr_en_b),
    .ld_we      (ld_we),
    .last_stage (last_stage)
  );

  coef_rom u_coef_rom (
    .clk     (clk),
    .stage   (stage),
    .weights (weights),
    .bias    (bias)
  );

  // host holds start_req for the whole run, so readout owns the port otherwise
  assign a_raddr = (!RESULT_IN_B && !start_req) ? rd_addr : rd_pos;
  assign b_raddr = (RESULT_IN_B && !start_req) ? rd_addr : rd_pos;

  // bank A takes the host map during loads
  assign a_wdata = ld_we ? ld_data : mac_y;

  feature_ram u_bank_a (
    .clk   (clk),
    .we    (wr_en_a || ld_we),
    .waddr (wr_pos),
    .wdata (a_wdata),
    .raddr (a_raddr),
    .rdata (a_rdata)
  );

  feature_ram u_bank_b (
    .clk   (clk),
    .we    (wr_en_b),
    .waddr (wr_pos),
    .wdata (mac_y),
    .raddr (b_raddr),
    .rdata (b_rdata)
  );

  feature_ram u_skip (
    .clk   (clk),
    .we    (ld_we),
    .waddr (wr_pos),
    .wdata (ld_data),
    .raddr (rd_pos),
    .rdata (skip_rdata)
  );

  assign mac_x = rd_bank_b ? b_rdata : a_rdata;

  // relu on every stage but the last, skip add only on the last
  mac_array u_mac_array (
    .clk       (clk),
    .reset     (reset),
    .valid_in  (issue),
    .relu_en   (!last_stage),
    .skip_en   (last_stage),
    .x         (mac_x),
    .weights   (weights),
    .bias      (bias),
    .skip      (skip_rdata),
    .y         (mac_y),
    .valid_out (mac_valid)
  );

  assign rd_data = RESULT_IN_B ? b_rdata : a_rdata;

  // sequencer write-back delay must track the MAC pipeline depth
  a_wb_aligned: assert property (@(posedge clk) disable iff (reset)
    mac_valid == (wr_en_a || wr_en_b))
    else $error("write-back out of step with MAC output");

endmodule

`default_nettype wire

// ==== conv_pkg.sv ====
`default_nettype none

`include "conv_settings.svh"

package conv_pkg;

  // one feature element
  typedef logic signed [`CONV_DATA_W-1:0] elem_t;

  // lane 0 sits in the low bits
  typedef logic [`CONV_LANES*`CONV_DATA_W-1:0] vec_t;

  typedef logic [`CONV_ADDR_W-1:0] addr_t;
  typedef logic [`CONV_STAGE_W-1:0] stage_t;

  // single weight
  typedef logic signed [`CONV_COEF_W-1:0] coef_t;

  // entry (i, j) at index i*LANES + j, i is the output lane
  typedef logic [`CONV_LANES*`CONV_LANES*`CONV_COEF_W-1:0] wmat_t;

  typedef logic signed [`CONV_ACC_W-1:0] acc_t;

  // sequencer FSM
  typedef enum logic [2:0] {IDLE, LOAD_ACK, RUN, DRAIN, DONE} seq_state_t;

endpackage

`default_nettype wire

// ==== conv_settings.svh ====
`ifndef CONV_SETTINGS_SVH
`define CONV_SETTINGS_SVH

// feature map geometry
`define CONV_LANES   4
`define CONV_DEPTH   16
`define CONV_ADDR_W  4

// stages per run, stage index width
`define CONV_STAGES  3
`define CONV_STAGE_W 2

// arithmetic right shift after the dot product
`define CONV_SHIFT   2

// element, weight and accumulator widths
`define CONV_DATA_W  16
`define CONV_COEF_W  8
`define CONV_ACC_W   32

`endif

// ==== feature_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "conv_settings.svh"

module feature_ram import conv_pkg::*; (
  input  wire        clk,
  input  wire        we,
  input  wire addr_t waddr,
  input  wire vec_t  wdata,
  input  wire addr_t raddr,
  output vec_t       rdata
);

  vec_t mem [`CONV_DEPTH];

  // read before write on an address collision
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
    rdata <= mem[raddr];
  end

  // writes from load and write-back paths must carry a known address
  a_waddr_known: assert property (@(posedge clk) we |-> !$isunknown(waddr))
    else $error("feature_ram write with unknown address");

endmodule

`default_nettype wire

// ==== layer_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "conv_settings.svh"

module layer_sequencer import conv_pkg::*; (
  input  wire        clk,
  input  wire        reset,
  input  wire        ld_req,
  input  wire addr_t ld_addr,
  input  wire        start_req,
  output logic       ld_ack,
  output logic       start_ack,
  output stage_t     stage,
  output addr_t      rd_pos,
  output logic       rd_bank_b,
  output logic       issue,
  output addr_t      wr_pos,
  output logic       wr_en_a,
  output logic       wr_en_b,
  output logic       ld_we,
  output logic       last_stage
);

  localparam addr_t  LAST_POS   = addr_t'(`CONV_DEPTH - 1);
  localparam stage_t LAST_STAGE = stage_t'(`CONV_STAGES - 1);
  // three datapath registers behind the read address
  localparam logic [1:0] DRAIN_LAST = 2'd2;

  seq_state_t state;
  stage_t     stage_q;
  addr_t      pos_q;
  logic [1:0] drain_cnt;

  // write-back pipeline, index = cycles after issue
  logic [1:3] iss_p;
  logic [1:3] rdb_p;
  addr_t      pos_p [1:3];
  logic       last_p1;

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= IDLE;
      stage_q   <= '0;
      pos_q     <= '0;
      drain_cnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          // a start request wins over a load
          if (start_req) begin
            state   <= RUN;
            stage_q <= '0;
            pos_q   <= '0;
          end else if (ld_req) begin
            state <= LOAD_ACK;
          end
        end
        LOAD_ACK: begin
          if (!ld_req) begin
            state <= IDLE;
          end
        end
        RUN: begin
          pos_q <= pos_q + 1'b1;
          if (pos_q == LAST_POS) begin
            state     <= DRAIN;
            drain_cnt <= '0;
          end
        end
        DRAIN: begin
          drain_cnt <= drain_cnt + 1'b1;
          if (drain_cnt == DRAIN_LAST) begin
            pos_q <= '0;
            if (stage_q == LAST_STAGE) begin
              state <= DONE;
            end else begin
              stage_q <= stage_q + 1'b1;
              state   <= RUN;
            end
          end
        end
        DONE: begin
          if (!start_req) begin
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      iss_p <= '0;
    end else begin
      iss_p <= {state == RUN, iss_p[1:2]};
    end
  end

  // even stages read bank A, odd stages read bank B
  always_ff @(posedge clk) begin
    pos_p[1] <= pos_q;
    pos_p[2] <= pos_p[1];
    pos_p[3] <= pos_p[2];
    rdb_p    <= {stage_q[0], rdb_p[1:2]};
    last_p1  <= (stage_q == LAST_STAGE);
  end

  assign ld_ack    = (state == LOAD_ACK);
  assign start_ack = (state == DONE);
  assign ld_we     = (state == IDLE) && ld_req && !start_req;

  assign stage      = stage_q;
  assign rd_pos     = pos_q;
  // aligned with the registered RAM and ROM outputs
  assign issue      = iss_p[1];
  assign rd_bank_b  = rdb_p[1];
  assign last_stage = last_p1;

  // results go to the bank that was not read
  assign wr_en_a = iss_p[3] && rdb_p[3];
  assign wr_en_b = iss_p[3] && !rdb_p[3];
  assign wr_pos  = ld_we ? ld_addr : pos_p[3];

  a_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
    $rose(start_ack) |-> start_req)
    else $error("start_ack rose without start_req");

  // write-back and load share wr_pos, so at most one writer per cycle
  a_one_bank_write: assert property (@(posedge clk) disable iff (reset)
    $onehot0({wr_en_a, wr_en_b, ld_we}))
    else $error("more than one write source active in one cycle");

  a_no_load_in_run: assert property (@(posedge clk) disable iff (reset)
    (state inside {RUN, DRAIN}) |-> !$rose(ld_req))
    else $error("load request while a run is active");

endmodule

`default_nettype wire

// ==== mac_array.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "conv_settings.svh"

module mac_array import conv_pkg::*; (
  input  wire        clk,
  input  wire        reset,
  input  wire        valid_in,
  input  wire        relu_en,
  input  wire        skip_en,
  input  wire vec_t  x,
  input  wire wmat_t weights,
  input  wire vec_t  bias,
  input  wire vec_t  skip,
  output vec_t       y,
  output logic       valid_out
);

  localparam int L = `CONV_LANES;
  localparam int W = `CONV_DATA_W;
  localparam int C = `CONV_COEF_W;
  localparam acc_t ELEM_MAX = acc_t'((1 << (W - 1)) - 1);
  localparam acc_t ELEM_MIN = acc_t'(-(1 << (W - 1)));

  acc_t prod [L*L];
  acc_t row_sum [L];
  vec_t bias_q;
  vec_t skip_q;
  logic relu_q;
  logic skip_en_q;
  logic valid_q;

  // shift, bias, optional skip, optional relu, then clamp to 16 bits
  function automatic elem_t finish_lane(acc_t sum, elem_t b, elem_t s,
                                        logic relu, logic add_skip);
    acc_t v;
    v = (sum >>> `CONV_SHIFT) + acc_t'(b);
    if (add_skip) begin
      v = v + acc_t'(s);
    end
    if (relu && v < 0) begin
      v = '0;
    end
    if (v > ELEM_MAX) begin
      v = ELEM_MAX;
    end else if (v < ELEM_MIN) begin
      v = ELEM_MIN;
    end
    return elem_t'(v);
  endfunction

  // stage one: all lane products
  always_ff @(posedge clk) begin
    for (int i = 0; i < L; i++) begin
      for (int j = 0; j < L; j++) begin
        prod[i*L+j] <= elem_t'(x[j*W +: W]) * coef_t'(weights[(i*L+j)*C +: C]);
      end
    end
    bias_q    <= bias;
    skip_q    <= skip;
    relu_q    <= relu_en;
    skip_en_q <= skip_en;
  end

  // row adder
  always_comb begin
    for (int i = 0; i < L; i++) begin
      row_sum[i] = '0;
      for (int j = 0; j < L; j++) begin
        row_sum[i] = row_sum[i] + prod[i*L+j];
      end
    end
  end

  // stage two: post-processing per output lane
  always_ff @(posedge clk) begin
    for (int i = 0; i < L; i++) begin
      y[i*W +: W] <= finish_lane(row_sum[i], elem_t'(bias_q[i*W +: W]),
                                 elem_t'(skip_q[i*W +: W]), relu_q, skip_en_q);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q   <= 1'b0;
      valid_out <= 1'b0;
    end else begin
      valid_q   <= valid_in;
      valid_out <= valid_q;
    end
  end

endmodule

`default_nettype wire

// ==== tb_conv_layer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "conv_settings.svh"

module tb_conv_layer import conv_pkg::*; ();

  localparam int L = `CONV_LANES;
  localparam int D = `CONV_DEPTH;
  localparam int S = `CONV_STAGES;
  localparam int W = `CONV_DATA_W;
  localparam int RUNS = 4;
  localparam int CLK_NS = 8;
  localparam int HS_LIMIT = 8;
  localparam int RUN_LIMIT = S * (D + 3) + 16;
  localparam longint WATCHDOG_NS = longint'(RUNS * (S * (D + 3) + D * 4) + 200) * CLK_NS;
  // last stage writes bank B (index 1) when its index is even
  localparam int RES_BANK = ((S - 1) % 2 == 0) ? 1 : 0;

  logic  clk = 1'b0;
  logic  reset;
  logic  ld_req;
  addr_t ld_addr;
  vec_t  ld_data;
  logic  start_req;
  addr_t rd_addr;
  logic  ld_ack;
  logic  start_ack;
  vec_t  rd_data;

  logic [15:0] lfsr_q;
  int value_errors = 0;
  int proto_errors = 0;
  int sat_hits;
  int relu_zeros;

  // model state, bank index 0 is A and 1 is B
  int stim [D][L];
  int bank_m [2][D][L];
  int skip_m [D][L];

  conv_layer_top u_conv_layer_top (
    .clk       (clk),
    .reset     (reset),
    .ld_req    (ld_req),
    .ld_addr   (ld_addr),
    .ld_data   (ld_data),
    .start_req (start_req),
    .rd_addr   (rd_addr),
    .ld_ack    (ld_ack),
    .start_ack (start_ack),
    .rd_data   (rd_data)
  );

  always #(CLK_NS / 2) clk = ~clk;

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: run still busy after %0d ns, a handshake never completed", WATCHDOG_NS);
    $display("Verification failed");
    $finish;
  end

  // galois lfsr, one step per output bit
  function automatic int random_bits(int n);
    int v;
    v = 0;
    for (int k = 0; k < n; k++) begin
      v = (v << 1) | int'(lfsr_q[0]);
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  function automatic int rule_weight(int s, int i, int j);
    return ((7 * s + 3 * i + 5 * j) % 11) - 5;
  endfunction

  function automatic int rule_bias(int s, int i);
    return ((13 * s + 9 * i) % 32) - 16;
  endfunction

  function automatic int clamp16(int v);
    if (v > 32767) begin
      return 32767;
    end
    if (v < -32768) begin
      return -32768;
    end
    return v;
  endfunction

  function automatic vec_t pack_vector(int p);
    vec_t v;
    v = '0;
    for (int i = 0; i < L; i++) begin
      v[i*W +: W] = elem_t'(stim[p][i]);
    end
    return v;
  endfunction

  // 10 bit values, sign extended
  task automatic fill_random_map();
    int b;
    for (int p = 0; p < D; p++) begin
      for (int i = 0; i < L; i++) begin
        b = random_bits(10);
        stim[p][i] = (b >= 512) ? b - 1024 : b;
      end
    end
  endtask

  // values near either 16-bit limit
  task automatic fill_large_map();
    int sgn;
    int off;
    for (int p = 0; p < D; p++) begin
      for (int i = 0; i < L; i++) begin
        sgn = random_bits(1);
        off = random_bits(8);
        stim[p][i] = (sgn == 1) ? 32767 - off : -32768 + off;
      end
    end
  endtask

  task automatic model_run();
    int src;
    int acc;
    int v;
    sat_hits = 0;
    relu_zeros = 0;
    for (int s = 0; s < S; s++) begin
      src = s % 2;
      for (int p = 0; p < D; p++) begin
        for (int i = 0; i < L; i++) begin
          acc = 0;
          for (int j = 0; j < L; j++) begin
            acc = acc + bank_m[src][p][j] * rule_weight(s, i, j);
          end
          v = (acc >>> `CONV_SHIFT) + rule_bias(s, i);
          if (s == S - 1) begin
            v = v + skip_m[p][i];
          end else if (v < 0) begin
            v = 0;
            relu_zeros++;
          end
          v = clamp16(v);
          if (s == S - 1 && (v == 32767 || v == -32768)) begin
            sat_hits++;
          end
          bank_m[1-src][p][i] = v;
        end
      end
    end
  endtask

  task automatic load_vector(input int pos, input vec_t data);
    int waited;
    assert (ld_ack == 1'b0) else begin
      proto_errors++;
      $display("ld_ack was high before ld_req for position %0d", pos);
    end
    ld_addr = addr_t'(pos);
    ld_data = data;
    ld_req = 1'b1;
    waited = 0;
    @(negedge clk);
    while (!ld_ack && waited < HS_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    assert (ld_ack == 1'b1) else begin
      proto_errors++;
      $display("ld_ack never rose for position %0d", pos);
    end
    // ack must hold while the request is still up
    @(negedge clk);
    assert (ld_ack == 1'b1) else begin
      proto_errors++;
      $display("ld_ack fell while ld_req was still high at position %0d", pos);
    end
    ld_req = 1'b0;
    waited = 0;
    @(negedge clk);
    while (ld_ack && waited < HS_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    assert (ld_ack == 1'b0) else begin
      proto_errors++;
      $display("ld_ack stayed high after ld_req fell at position %0d", pos);
    end
  endtask

  task automatic load_map();
    for (int p = 0; p < D; p++) begin
      load_vector(p, pack_vector(p));
      for (int i = 0; i < L; i++) begin
        bank_m[0][p][i] = stim[p][i];
        skip_m[p][i] = stim[p][i];
      end
    end
  endtask

  task automatic run_layer(input string name);
    int waited;
    assert (start_ack == 1'b0) else begin
      proto_errors++;
      $display("%s: start_ack high before start_req", name);
    end
    start_req = 1'b1;
    waited = 0;
    @(negedge clk);
    while (!start_ack && waited < RUN_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    assert (start_ack == 1'b1) else begin
      proto_errors++;
      $display("%s: start_ack never rose", name);
    end
    @(negedge clk);
    assert (start_ack == 1'b1) else begin
      proto_errors++;
      $display("%s: start_ack fell while start_req was still high", name);
    end
    start_req = 1'b0;
    @(negedge clk);
    assert (start_ack == 1'b0) else begin
      proto_errors++;
      $display("%s: start_ack did not fall the cycle after start_req fell", name);
    end
  endtask

  task automatic check_results(input string name);
    elem_t got;
    int exp_val;
    for (int p = 0; p < D; p++) begin
      rd_addr = addr_t'(p);
      @(negedge clk);
      for (int i = 0; i < L; i++) begin
        got = elem_t'(rd_data[i*W +: W]);
        exp_val = bank_m[RES_BANK][p][i];
        assert (int'(got) == exp_val) else begin
          value_errors++;
          $display("ERR %s pos %0d lane %0d expected %0d actual %0d",
                   name, p, i, exp_val, int'(got));
        end
      end
    end
  endtask

  initial begin
    reset = 1'b1;
    ld_req = 1'b0;
    ld_addr = '0;
    ld_data = '0;
    start_req = 1'b0;
    rd_addr = '0;
    lfsr_q = 16'd16;
    repeat (4) @(negedge clk);
    reset = 1'b0;

    assert (ld_ack == 1'b0 && start_ack == 1'b0) else begin
      proto_errors++;
      $display("acks not low after reset");
    end

    fill_random_map();
    load_map();
    model_run();
    run_layer("random");
    check_results("random");

    fill_large_map();
    load_map();
    model_run();
    assert (sat_hits > 0 && relu_zeros > 0) else begin
      proto_errors++;
      $display("large-value map missed the limits or a relu clip");
    end
    run_layer("saturate");
    check_results("saturate");

    fill_random_map();
    load_map();
    model_run();
    run_layer("reload");
    check_results("reload");

    // no load, bank A holds the stage 1 output of the last run
    model_run();
    run_layer("no_load");
    check_results("no_load");

    $display("value errors: %0d, protocol errors: %0d", value_errors, proto_errors);
    if (value_errors == 0 && proto_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
